// ==== axi_burst_slave.f ====
+incdir+common
common/axb_pkg.sv
design/txn_fifo.sv
burst/burst_addr_gen.sv
design/read_data_stage.sv
design/write_data_stage.sv
design/word_ram.sv
design/axi_burst_slave.sv
test/axi_burst_slave_asserts.sv
test/axi_burst_slave_tb.sv

// ==== Bender.yml ====
package:
  name: axi_burst_slave

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axb_pkg.sv
      - design/txn_fifo.sv
      - burst/burst_addr_gen.sv
      - design/read_data_stage.sv
      - design/write_data_stage.sv
      - design/word_ram.sv
      - design/axi_burst_slave.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/axi_burst_slave_asserts.sv
      - test/axi_burst_slave_tb.sv

// ==== test/axi_burst_slave_tb.sv ====
//*********************************************************************
// axi_burst_slave_tb
// table-driven testbench, reference word memory and R/B monitors
//*********************************************************************

`include "axb_config.svh"

module axi_burst_slave_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_rows = 11;
    localparam int bytes    = `AXB_DATA_WIDTH / 8;

    // one table row: operation, ID, start address, length, kind, strobe
    typedef struct packed {
        logic                       is_write;
        axb_pkg::axi_id_t           id;
        logic [`AXB_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        axb_pkg::burst_e            burst;
        logic [`AXB_STRB_WIDTH-1:0] strb;
    } row_t;

    logic                       S_AXI_ACLK;
    logic                       S_AXI_ARESETN;
    axb_pkg::axi_id_t           S_AXI_AWID;
    axb_pkg::axi_id_t           S_AXI_BID;
    axb_pkg::axi_id_t           S_AXI_ARID;
    axb_pkg::axi_id_t           S_AXI_RID;
    logic [`AXB_ADDR_WIDTH-1:0] S_AXI_AWADDR;
    logic [`AXB_ADDR_WIDTH-1:0] S_AXI_ARADDR;
    logic [7:0]                 S_AXI_AWLEN;
    logic [7:0]                 S_AXI_ARLEN;
    logic [1:0]                 S_AXI_AWBURST;
    logic [1:0]                 S_AXI_ARBURST;
    logic [`AXB_DATA_WIDTH-1:0] S_AXI_WDATA;
    logic [`AXB_DATA_WIDTH-1:0] S_AXI_RDATA;
    logic [`AXB_STRB_WIDTH-1:0] S_AXI_WSTRB;
    logic                       S_AXI_AWVALID;
    logic                       S_AXI_AWREADY;
    logic                       S_AXI_WVALID;
    logic                       S_AXI_WREADY;
    logic                       S_AXI_BVALID;
    logic                       S_AXI_BREADY;
    logic                       S_AXI_ARVALID;
    logic                       S_AXI_ARREADY;
    logic                       S_AXI_RVALID;
    logic                       S_AXI_RREADY;
    logic                       S_AXI_RLAST;

    row_t                       rows [num_rows];
    logic [`AXB_DATA_WIDTH-1:0] ref_mem [`AXB_MEM_WORDS];
    logic [`AXB_DATA_WIDTH-1:0] exp_rdata [$];
    axb_pkg::axi_id_t           exp_rid [$];
    logic                       exp_rlast [$];
    axb_pkg::axi_id_t           exp_bid [$];
    integer                     seed = 32'h0ac8_0245;
    int                         errors = 0;
    int                         writes_sent = 0;
    int                         b_seen = 0;

    axi_burst_slave DUT (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at time %0t: %s got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    function automatic int word_index(input logic [`AXB_ADDR_WIDTH-1:0] addr);
        return (addr / bytes) % `AXB_MEM_WORDS;
    endfunction

    // address of beat n, straight from the burst kind
    function automatic logic [`AXB_ADDR_WIDTH-1:0] beat_address(input row_t r, input int n);
        int word_start;
        int span;
        int base;
        word_start = (r.addr / bytes) * bytes;
        span       = (r.len + 1) * bytes;
        if (n == 0 || r.burst == axb_pkg::FIXED) return r.addr;
        if (r.burst == axb_pkg::WRAP) begin
            base = word_start - (word_start % span);
            return base + ((word_start - base + n * bytes) % span);
        end
        return word_start + n * bytes;  // INCR
    endfunction

    task automatic send_write(input row_t r);
        logic [`AXB_DATA_WIDTH-1:0] data;
        int                         widx;
        // earlier reads finish before memory changes
        while (exp_rdata.size() != 0) @(posedge S_AXI_ACLK);
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_AWID    = r.id;
        S_AXI_AWADDR  = r.addr;
        S_AXI_AWLEN   = r.len;
        S_AXI_AWBURST = r.burst;
        S_AXI_AWVALID = 1'b1;
        @(negedge S_AXI_ACLK);
        while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
        exp_bid.push_back(r.id);
        writes_sent++;
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_AWVALID = 1'b0;
        for (int n = 0; n <= r.len; n++) begin
            data = $random(seed);
            widx = word_index(beat_address(r, n));
            for (int b = 0; b < bytes; b++) begin
                if (r.strb[b]) ref_mem[widx][b*8 +: 8] = data[b*8 +: 8];
            end
            S_AXI_WDATA  = data;
            S_AXI_WSTRB  = r.strb;
            S_AXI_WVALID = 1'b1;
            @(negedge S_AXI_ACLK);
            while (!S_AXI_WREADY) @(negedge S_AXI_ACLK);
            @(posedge S_AXI_ACLK);
            #1;
        end
        S_AXI_WVALID = 1'b0;
    endtask

    // queues the expected beats, does not wait for the data
    task automatic send_read(input row_t r);
        for (int n = 0; n <= r.len; n++) begin
            exp_rdata.push_back(ref_mem[word_index(beat_address(r, n))]);
            exp_rid.push_back(r.id);
            exp_rlast.push_back(n == r.len);
        end
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARID    = r.id;
        S_AXI_ARADDR  = r.addr;
        S_AXI_ARLEN   = r.len;
        S_AXI_ARBURST = r.burst;
        S_AXI_ARVALID = 1'b1;
        @(negedge S_AXI_ACLK);
        while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
        @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARVALID = 1'b0;
    endtask

    // random ready pattern on R and B
    always @(posedge S_AXI_ACLK) begin
        #1;
        S_AXI_RREADY = ($random(seed) & 3) != 0;
        S_AXI_BREADY = ($random(seed) & 1) != 0;
    end

    // negedge sees what the next rising edge transfers
    always @(negedge S_AXI_ACLK) begin
        if (S_AXI_ARESETN && S_AXI_RVALID && S_AXI_RREADY) begin
            if (exp_rdata.size() == 0) begin
                errors++;
                $display("read beat at time %0t with RID %0h was not expected", $time, S_AXI_RID);
            end else begin
                compare_value("RDATA", S_AXI_RDATA, exp_rdata.pop_front());
                compare_value("RID", S_AXI_RID, exp_rid.pop_front());
                compare_value("RLAST", S_AXI_RLAST, exp_rlast.pop_front());
            end
        end
        if (S_AXI_ARESETN && S_AXI_BVALID && S_AXI_BREADY) begin
            b_seen++;
            if (exp_bid.size() == 0) begin
                errors++;
                $display("write response at time %0t with BID %0h was not expected",
                         $time, S_AXI_BID);
            end else begin
                compare_value("BID", S_AXI_BID, exp_bid.pop_front());
            end
        end
    end

    initial begin
        repeat (num_rows * 200) @(posedge S_AXI_ACLK);
        $display("timeout: transfers still pending after %0d clock cycles", num_rows * 200);
        $display("Checks failed");
        $finish;
    end

    initial begin
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWID    = '0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWLEN   = '0;
        S_AXI_AWBURST = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARID    = '0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARLEN   = '0;
        S_AXI_ARBURST = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        rows = '{
            '{1'b1, 4'h1, 16'h0040, 8'd7, axb_pkg::INCR,  4'hf},  // 8 beat INCR
            '{1'b0, 4'h2, 16'h0040, 8'd7, axb_pkg::INCR,  4'hf},
            '{1'b1, 4'h3, 16'h0080, 8'd3, axb_pkg::FIXED, 4'hf},  // last beat wins
            '{1'b0, 4'h4, 16'h0080, 8'd3, axb_pkg::FIXED, 4'hf},
            '{1'b1, 4'h5, 16'h00c8, 8'd3, axb_pkg::WRAP,  4'hf},  // mid window start
            '{1'b0, 4'h6, 16'h00c8, 8'd3, axb_pkg::WRAP,  4'hf},
            '{1'b1, 4'h7, 16'h0044, 8'd1, axb_pkg::INCR,  4'h5},  // partial strobes
            '{1'b1, 4'h8, 16'h004c, 8'd0, axb_pkg::INCR,  4'h8},
            '{1'b0, 4'h9, 16'h0040, 8'd3, axb_pkg::INCR,  4'hf},  // three reads in a row
            '{1'b0, 4'ha, 16'h00c0, 8'd3, axb_pkg::INCR,  4'hf},
            '{1'b0, 4'hb, 16'h0080, 8'd1, axb_pkg::FIXED, 4'hf}
        };
        repeat (2) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);
        compare_value("ARREADY after reset", S_AXI_ARREADY, 1'b1);
        compare_value("AWREADY after reset", S_AXI_AWREADY, 1'b1);
        compare_value("RVALID after reset", S_AXI_RVALID, 1'b0);
        compare_value("WREADY after reset", S_AXI_WREADY, 1'b0);
        compare_value("BVALID after reset", S_AXI_BVALID, 1'b0);
        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].is_write) send_write(rows[i]);
            else send_read(rows[i]);
        end
        while (exp_rdata.size() != 0 || exp_bid.size() != 0) @(posedge S_AXI_ACLK);
        repeat (10) @(posedge S_AXI_ACLK);  // room for a stray beat
        compare_value("write response count", b_seen, writes_sent);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== test/axi_burst_slave_asserts.sv ====
//*********************************************************************
// axi_burst_slave_asserts
// R hold, B hold and W flow control properties, bound to the DUT
//*********************************************************************

`include "axb_config.svh"

module axi_burst_slave_asserts (
    input logic                       S_AXI_ACLK,
    input logic                       S_AXI_ARESETN,
    input logic                       rvalid,
    input logic                       rready,
    input logic                       rlast,
    input logic [`AXB_DATA_WIDTH-1:0] rdata,
    input axb_pkg::axi_id_t           rid,
    input logic                       bvalid,
    input logic                       bready,
    input axb_pkg::axi_id_t           bid,
    input logic                       wready,
    input logic                       resp_push
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [$clog2(`AXB_QUEUE_DEPTH):0] resp_level;  // responses pushed, not yet taken on B

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            resp_level <= '0;
        end else if (resp_push && !(bvalid && bready)) begin
            resp_level <= resp_level + 1'b1;
        end else if (bvalid && bready && !resp_push) begin
            resp_level <= resp_level - 1'b1;
        end
    end

    // stalled R beat keeps its payload
    r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
        else $error("R channel changed while RVALID was held off by RREADY");

    b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        bvalid && !bready |=> bvalid && $stable(bid))
        else $error("BVALID or BID changed before BREADY");

    // a full response queue holds AXB_QUEUE_DEPTH entries
    w_room: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wready |-> resp_level < `AXB_QUEUE_DEPTH)
        else $error("WREADY was high while the response queue was full");

endmodule

bind axi_burst_slave axi_burst_slave_asserts u_asserts (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rlast         (S_AXI_RLAST),
    .rdata         (S_AXI_RDATA),
    .rid           (S_AXI_RID),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .bid           (S_AXI_BID),
    .wready        (S_AXI_WREADY),
    .resp_push     (resp_push)
);

// ==== design/axi_burst_slave.sv ====
//*********************************************************************
// axi_burst_slave
// AXI4 burst slave over a word memory, queued AR and AW with
// in-order R and B
//*********************************************************************

`include "axb_config.svh"

module axi_burst_slave (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,

    // write address
    input  axb_pkg::axi_id_t           S_AXI_AWID,
    input  logic [`AXB_ADDR_WIDTH-1:0] S_AXI_AWADDR,
    input  logic [7:0]                 S_AXI_AWLEN,
    input  logic [1:0]                 S_AXI_AWBURST,
    input  logic                       S_AXI_AWVALID,
    output logic                       S_AXI_AWREADY,

    // write data
    input  logic [`AXB_DATA_WIDTH-1:0] S_AXI_WDATA,
    input  logic [`AXB_STRB_WIDTH-1:0] S_AXI_WSTRB,
    input  logic                       S_AXI_WVALID,
    output logic                       S_AXI_WREADY,

    // write response
    output axb_pkg::axi_id_t           S_AXI_BID,
    output logic                       S_AXI_BVALID,
    input  logic                       S_AXI_BREADY,

    // read address
    input  axb_pkg::axi_id_t           S_AXI_ARID,
    input  logic [`AXB_ADDR_WIDTH-1:0] S_AXI_ARADDR,
    input  logic [7:0]                 S_AXI_ARLEN,
    input  logic [1:0]                 S_AXI_ARBURST,
    input  logic                       S_AXI_ARVALID,
    output logic                       S_AXI_ARREADY,

    // read data
    output axb_pkg::axi_id_t           S_AXI_RID,
    output logic [`AXB_DATA_WIDTH-1:0] S_AXI_RDATA,
    output logic                       S_AXI_RLAST,
    output logic                       S_AXI_RVALID,
    input  logic                       S_AXI_RREADY
);

    axb_pkg::burst_req_t        ar_req;
    axb_pkg::burst_req_t        ar_head;
    logic                       ar_head_valid;
    logic                       ar_pop;
    axb_pkg::burst_req_t        aw_req;
    axb_pkg::burst_req_t        aw_head;
    logic                       aw_head_valid;
    logic                       aw_pop;

    logic                       rd_beat_valid;
    logic [`AXB_ADDR_WIDTH-1:0] rd_beat_addr;
    axb_pkg::axi_id_t           rd_beat_id;
    logic                       rd_beat_last;
    logic                       rd_step;
    logic                       wr_beat_valid;
    logic [`AXB_ADDR_WIDTH-1:0] wr_beat_addr;
    axb_pkg::axi_id_t           wr_beat_id;
    logic                       wr_beat_last;
    logic                       wr_step;

    logic                       ram_ren;
    logic [`AXB_WIDX_WIDTH-1:0] ram_raddr;
    logic                       ram_wen;
    logic [`AXB_WIDX_WIDTH-1:0] ram_waddr;

    logic                       resp_ready;
    logic                       resp_push;
    axb_pkg::axi_id_t           resp_id;

    // pack the address channels into queue entries
    assign ar_req = '{addr: S_AXI_ARADDR, id: S_AXI_ARID, len: S_AXI_ARLEN,
                      burst: axb_pkg::burst_e'(S_AXI_ARBURST)};
    assign aw_req = '{addr: S_AXI_AWADDR, id: S_AXI_AWID, len: S_AXI_AWLEN,
                      burst: axb_pkg::burst_e'(S_AXI_AWBURST)};

    txn_fifo #(
        .payload_t (axb_pkg::burst_req_t),
        .depth     (`AXB_QUEUE_DEPTH)
    ) u_ar_queue (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push          (S_AXI_ARVALID),  // qualified by in_ready inside
        .in_data       (ar_req),
        .in_ready      (S_AXI_ARREADY),
        .pop           (ar_pop),
        .out_valid     (ar_head_valid),
        .out_data      (ar_head)
    );

    txn_fifo #(
        .payload_t (axb_pkg::burst_req_t),
        .depth     (`AXB_QUEUE_DEPTH)
    ) u_aw_queue (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push          (S_AXI_AWVALID),
        .in_data       (aw_req),
        .in_ready      (S_AXI_AWREADY),
        .pop           (aw_pop),
        .out_valid     (aw_head_valid),
        .out_data      (aw_head)
    );

    txn_fifo #(
        .payload_t (axb_pkg::axi_id_t),
        .depth     (`AXB_QUEUE_DEPTH)
    ) u_b_queue (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .push          (resp_push),
        .in_data       (resp_id),
        .in_ready      (resp_ready),
        .pop           (S_AXI_BREADY),  // only takes effect with BVALID
        .out_valid     (S_AXI_BVALID),
        .out_data      (S_AXI_BID)
    );

    burst_addr_gen u_rd_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req_valid     (ar_head_valid),
        .req           (ar_head),
        .req_pop       (ar_pop),
        .beat_valid    (rd_beat_valid),
        .beat_addr     (rd_beat_addr),
        .beat_id       (rd_beat_id),
        .beat_last     (rd_beat_last),
        .beat_step     (rd_step)
    );

    burst_addr_gen u_wr_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req_valid     (aw_head_valid),
        .req           (aw_head),
        .req_pop       (aw_pop),
        .beat_valid    (wr_beat_valid),
        .beat_addr     (wr_beat_addr),
        .beat_id       (wr_beat_id),
        .beat_last     (wr_beat_last),
        .beat_step     (wr_step)
    );

    read_data_stage u_rd_stage (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .beat_valid    (rd_beat_valid),
        .beat_addr     (rd_beat_addr),
        .beat_id       (rd_beat_id),
        .beat_last     (rd_beat_last),
        .beat_step     (rd_step),
        .ram_ren       (ram_ren),
        .ram_raddr     (ram_raddr),
        .rvalid        (S_AXI_RVALID),
        .rid           (S_AXI_RID),
        .rlast         (S_AXI_RLAST),
        .rready        (S_AXI_RREADY)
    );

    write_data_stage u_wr_stage (
        .beat_valid (wr_beat_valid),
        .beat_addr  (wr_beat_addr),
        .beat_id    (wr_beat_id),
        .beat_last  (wr_beat_last),
        .beat_step  (wr_step),
        .wvalid     (S_AXI_WVALID),
        .wready     (S_AXI_WREADY),
        .ram_wen    (ram_wen),
        .ram_waddr  (ram_waddr),
        .resp_ready (resp_ready),
        .resp_push  (resp_push),
        .resp_id    (resp_id)
    );

    // RDATA comes straight from the read register
    word_ram u_ram (
        .S_AXI_ACLK (S_AXI_ACLK),
        .wen        (ram_wen),
        .waddr      (ram_waddr),
        .wdata      (S_AXI_WDATA),
        .wstrb      (S_AXI_WSTRB),
        .ren        (ram_ren),
        .raddr      (ram_raddr),
        .rdata      (S_AXI_RDATA)
    );

endmodule

// ==== design/word_ram.sv ====
//*********************************************************************
// word_ram
// word memory, byte strobed write port and registered read port
//*********************************************************************

`include "axb_config.svh"

module word_ram (
    input  logic                       S_AXI_ACLK,
    input  logic                       wen,
    input  logic [`AXB_WIDX_WIDTH-1:0] waddr,
    input  logic [`AXB_DATA_WIDTH-1:0] wdata,
    input  logic [`AXB_STRB_WIDTH-1:0] wstrb,
    input  logic                       ren,
    input  logic [`AXB_WIDX_WIDTH-1:0] raddr,
    output logic [`AXB_DATA_WIDTH-1:0] rdata
);

    logic [`AXB_DATA_WIDTH-1:0] mem [`AXB_MEM_WORDS];

    always_ff @(posedge S_AXI_ACLK) begin
        if (wen) begin
            for (int b = 0; b < `AXB_STRB_WIDTH; b++) begin
                if (wstrb[b]) mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // read register holds until the next ren
    always_ff @(posedge S_AXI_ACLK) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== design/write_data_stage.sv ====
//*********************************************************************
// write_data_stage
// W beat handshake, memory write and write response push
//*********************************************************************

`include "axb_config.svh"

module write_data_stage (
    input  logic                       beat_valid,
    input  logic [`AXB_ADDR_WIDTH-1:0] beat_addr,
    input  axb_pkg::axi_id_t           beat_id,
    input  logic                       beat_last,
    output logic                       beat_step,
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       ram_wen,
    output logic [`AXB_WIDX_WIDTH-1:0] ram_waddr,
    input  logic                       resp_ready,
    output logic                       resp_push,
    output axb_pkg::axi_id_t           resp_id
);

    localparam int byte_offset = $clog2(`AXB_DATA_WIDTH / 8);

    logic accept;

    // hold off W while no beat or no room for the response
    assign wready = beat_valid && resp_ready;
    assign accept = wvalid && wready;

    assign beat_step = accept;
    assign ram_wen   = accept;
    assign ram_waddr = beat_addr[byte_offset +: `AXB_WIDX_WIDTH];

    assign resp_push = accept && beat_last;  // one response per burst
    assign resp_id   = beat_id;

endmodule

// ==== design/read_data_stage.sv ====
//*********************************************************************
// read_data_stage
// issues memory reads and drives the R channel side signals
//*********************************************************************

`include "axb_config.svh"

module read_data_stage (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic                       beat_valid,
    input  logic [`AXB_ADDR_WIDTH-1:0] beat_addr,
    input  axb_pkg::axi_id_t           beat_id,
    input  logic                       beat_last,
    output logic                       beat_step,
    output logic                       ram_ren,
    output logic [`AXB_WIDX_WIDTH-1:0] ram_raddr,
    output logic                       rvalid,
    output axb_pkg::axi_id_t           rid,
    output logic                       rlast,
    input  logic                       rready
);

    localparam int byte_offset = $clog2(`AXB_DATA_WIDTH / 8);

    logic issue;

    // output slot empty or being taken this cycle
    assign issue     = beat_valid && (!rvalid || rready);
    assign beat_step = issue;
    assign ram_ren   = issue;
    assign ram_raddr = beat_addr[byte_offset +: `AXB_WIDX_WIDTH];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rvalid <= 1'b0;
        end else if (issue) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // lines up with the memory read register
    always_ff @(posedge S_AXI_ACLK) begin
        if (issue) begin
            rid   <= beat_id;
            rlast <= beat_last;
        end
    end

endmodule

// ==== burst/burst_addr_gen.sv ====
//*********************************************************************
// burst_addr_gen
// takes one queued burst and steps its beat address and count
//*********************************************************************

`include "axb_config.svh"

module burst_addr_gen (
    input  logic                       S_AXI_ACLK,
    input  logic                       S_AXI_ARESETN,
    input  logic                       req_valid,
    input  axb_pkg::burst_req_t        req,
    output logic                       req_pop,
    output logic                       beat_valid,
    output logic [`AXB_ADDR_WIDTH-1:0] beat_addr,
    output axb_pkg::axi_id_t           beat_id,
    output logic                       beat_last,
    input  logic                       beat_step
);

    localparam int addr_w      = `AXB_ADDR_WIDTH;
    localparam int byte_offset = $clog2(`AXB_DATA_WIDTH / 8);

    logic                  active;
    logic [7:0]            beat_cnt;
    logic [7:0]            len;
    axb_pkg::burst_e       kind;
    axb_pkg::axi_id_t      id;
    logic [addr_w-1:0]     cur_addr;
    logic [addr_w-1:0]     aligned;
    logic [addr_w-1:0]     incr_addr;
    logic [addr_w-1:0]     wrap_mask;
    logic [addr_w-1:0]     next_addr;
    logic                  advance;

    assign req_pop    = req_valid && !active;  // load head as soon as idle
    assign beat_valid = active;
    assign beat_addr  = cur_addr;
    assign beat_id    = id;
    assign beat_last  = (beat_cnt == len);
    assign advance    = active && beat_step;

    // later beats always sit on a word boundary
    assign aligned   = {cur_addr[addr_w-1:byte_offset], {byte_offset{1'b0}}};
    assign incr_addr = aligned + (addr_w'(1) << byte_offset);

    // wrap window is (len+1) words, a power of two for legal WRAP lengths
    assign wrap_mask = ((addr_w'(len) + 1'b1) << byte_offset) - 1'b1;

    always_comb begin
        case (kind)
            axb_pkg::FIXED: next_addr = cur_addr;
            axb_pkg::WRAP:  next_addr = (aligned & ~wrap_mask) | (incr_addr & wrap_mask);
            default:        next_addr = incr_addr;  // INCR and reserved code
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (req_pop) begin
            active   <= 1'b1;
            beat_cnt <= '0;
        end else if (advance) begin
            if (beat_last) begin
                active <= 1'b0;  // idle, next burst loads next cycle
            end
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // burst fields, only meaningful while active
    always_ff @(posedge S_AXI_ACLK) begin
        if (req_pop) begin
            cur_addr <= req.addr;
            len      <= req.len;
            kind     <= req.burst;
            id       <= req.id;
        end else if (advance) begin
            cur_addr <= next_addr;
        end
    end

endmodule

// ==== design/txn_fifo.sv ====
//*********************************************************************
// txn_fifo
// small in-order queue, payload set by a type parameter
//*********************************************************************

module txn_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     S_AXI_ACLK,
    input  logic     S_AXI_ARESETN,
    input  logic     push,
    input  payload_t in_data,
    output logic     in_ready,
    input  logic     pop,
    output logic     out_valid,
    output payload_t out_data
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

    payload_t               buffer [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width:0]     count;
    logic                   do_push;
    logic                   do_pop;

    // circular pointer step, depth need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != (ptr_width + 1)'(depth));  // not full
    assign out_valid = (count != '0);
    assign out_data  = buffer[rd_ptr];

    assign do_push = push && in_ready;
    assign do_pop  = pop && out_valid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (do_push) buffer[wr_ptr] <= in_data;
    end

endmodule

// ==== common/axb_pkg.sv ====
//*********************************************************************
// axb_pkg
// burst kind, transaction ID and queued request types
//*********************************************************************

`include "axb_config.svh"

package axb_pkg;

    // AXI AxBURST encoding, 2'b11 is reserved and handled as INCR
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef logic [`AXB_ID_WIDTH-1:0] axi_id_t;

    // one queued AR or AW request
    typedef struct packed {
        logic [`AXB_ADDR_WIDTH-1:0] addr;  // start byte address
        axi_id_t                    id;
        logic [7:0]                 len;   // beats minus one
        burst_e                     burst;
    } burst_req_t;

endpackage

// ==== common/axb_config.svh ====
//*********************************************************************
// axb config
// widths, queue depth and memory size of the AXI4 burst slave
//*********************************************************************

`ifndef AXB_CONFIG_SVH
`define AXB_CONFIG_SVH

// AXI bus widths
`define AXB_ADDR_WIDTH 16
`define AXB_DATA_WIDTH 32
`define AXB_ID_WIDTH 4

`define AXB_STRB_WIDTH (`AXB_DATA_WIDTH / 8)  // one strobe bit per byte

// outstanding bursts per request queue, also response queue depth
`define AXB_QUEUE_DEPTH 4

// word memory, index is taken modulo this size
`define AXB_MEM_WORDS 256
`define AXB_WIDX_WIDTH $clog2(`AXB_MEM_WORDS)

`endif
